// ==== test/lbus_rx_vectors.txt ====
// each row has 11 words: data of segments 0 to 3, control, expected tkeep, flags,
// then expected tdata as four 128-bit slices from the top (bits 511:384 first)
// control holds four hex digits per segment, segment 0 first: ena eop mty err
// flags holds three hex digits: tvalid tlast tuser
// idle, disabled segments carry eop, mty and err
ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff
0151015101510151 0000000000000000 000
00000000000000000000000000000000 00000000000000000000000000000000
00000000000000000000000000000000 00000000000000000000000000000000
// full beat, no end of packet
100102030405060708090a0b0c0d0e0f 110102030405060708090a0b0c0d0e0f
120102030405060708090a0b0c0d0e0f 130102030405060708090a0b0c0d0e0f
1000100010001000 ffffffffffffffff 100
100102030405060708090a0b0c0d0e0f 110102030405060708090a0b0c0d0e0f
120102030405060708090a0b0c0d0e0f 130102030405060708090a0b0c0d0e0f
// end of packet in segment 3, nothing empty
200102030405060708090a0b0c0d0e0f 210102030405060708090a0b0c0d0e0f
220102030405060708090a0b0c0d0e0f 230102030405060708090a0b0c0d0e0f
1000100010001100 ffffffffffffffff 110
200102030405060708090a0b0c0d0e0f 210102030405060708090a0b0c0d0e0f
220102030405060708090a0b0c0d0e0f 230102030405060708090a0b0c0d0e0f
// end of packet in segment 1, 5 empty bytes
300102030405060708090a0b0c0d0e0f 310102030405060708090a0b0c0d0e0f
320102030405060708090a0b0c0d0e0f 330102030405060708090a0b0c0d0e0f
1000115000000000 ffffffe000000000 110
300102030405060708090a0b0c0d0e0f 310102030405060708090a0000000000
00000000000000000000000000000000 00000000000000000000000000000000
// first beat with an error in segment 2
400102030405060708090a0b0c0d0e0f 410102030405060708090a0b0c0d0e0f
420102030405060708090a0b0c0d0e0f 430102030405060708090a0b0c0d0e0f
1000100010011000 ffffffffffffffff 100
400102030405060708090a0b0c0d0e0f 410102030405060708090a0b0c0d0e0f
420102030405060708090a0b0c0d0e0f 430102030405060708090a0b0c0d0e0f
// last beat of the bad packet, one byte in segment 0
500102030405060708090a0b0c0d0e0f 510102030405060708090a0b0c0d0e0f
520102030405060708090a0b0c0d0e0f 530102030405060708090a0b0c0d0e0f
11f0000000000000 8000000000000000 111
50000000000000000000000000000000 00000000000000000000000000000000
00000000000000000000000000000000 00000000000000000000000000000000
// clean packet, end in segment 2 with 8 empty bytes
600102030405060708090a0b0c0d0e0f 610102030405060708090a0b0c0d0e0f
620102030405060708090a0b0c0d0e0f 630102030405060708090a0b0c0d0e0f
1000100011800000 ffffffffff000000 110
600102030405060708090a0b0c0d0e0f 610102030405060708090a0b0c0d0e0f
62010203040506070000000000000000 00000000000000000000000000000000
// error on the end segment itself, 1 empty byte
700102030405060708090a0b0c0d0e0f 710102030405060708090a0b0c0d0e0f
720102030405060708090a0b0c0d0e0f 730102030405060708090a0b0c0d0e0f
1000100010001111 fffffffffffffffe 111
700102030405060708090a0b0c0d0e0f 710102030405060708090a0b0c0d0e0f
720102030405060708090a0b0c0d0e0f 730102030405060708090a0b0c0d0e00
// end in segment 0, errors only on disabled segments
800102030405060708090a0b0c0d0e0f 810102030405060708090a0b0c0d0e0f
820102030405060708090a0b0c0d0e0f 830102030405060708090a0b0c0d0e0f
1100010100010001 ffff000000000000 110
800102030405060708090a0b0c0d0e0f 00000000000000000000000000000000
00000000000000000000000000000000 00000000000000000000000000000000
// idle
00000000000000000000000000000000 00000000000000000000000000000000
00000000000000000000000000000000 00000000000000000000000000000000
0000000000000000 0000000000000000 000
00000000000000000000000000000000 00000000000000000000000000000000
00000000000000000000000000000000 00000000000000000000000000000000

// ==== lbus_rx.f ====
rtl/lbus_rx_pkg.sv
rtl/lbus_seg_decode.sv
rtl/lbus_beat_assemble.sv
rtl/axis_byte_order.sv
rtl/lbus_rx_top.sv
test/tb_lbus_rx_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lbus receive testbench with verilator
set -e

cd "$(dirname "$0")"

top=tb_lbus_rx_top
log=sim.log

verilator --binary -j 0 --top-module "$top" -f lbus_rx.f -o "$top"

./obj_dir/"$top" > "$log" 2>&1
cat "$log"

# pass only when the testbench printed its pass line
if grep -qF "*** PASSED ***" "$log"; then
	echo "simulation passed"
else
	echo "simulation failed, see $log"
	exit 1
fi

// ==== test/tb_lbus_rx_top.sv ====
`timescale 1ns/10ps

module tb_lbus_rx_top;

	localparam int rx_input_reg = 1;
	localparam int big_endian = 1;
	localparam int latency = 2 + rx_input_reg;
	localparam int clk_period = 20;
	localparam int reset_cycles = 3;

	localparam int seg_count = lbus_rx_pkg::seg_count;
	localparam int seg_bytes = lbus_rx_pkg::seg_bytes;
	localparam int beat_bytes = lbus_rx_pkg::beat_bytes;
	localparam int seg_bits = seg_bytes * 8;

	// vector file layout
	localparam int vec_rows = 10;
	localparam int words_per_row = 11;
	localparam int rand_rows = 200;
	localparam int total_rows = vec_rows + rand_rows;

	logic rx_clk;
	logic rst_n;
	lbus_rx_pkg::seg_data_t rx_lbus_data [seg_count];
	logic [seg_count-1:0] rx_lbus_ena;
	logic [seg_count-1:0] rx_lbus_eop;
	lbus_rx_pkg::seg_mty_t rx_lbus_mty [seg_count];
	logic [seg_count-1:0] rx_lbus_err;
	lbus_rx_pkg::beat_data_t m_axis_tdata;
	lbus_rx_pkg::beat_keep_t m_axis_tkeep;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tuser;

	// stimulus and expected beat per row
	lbus_rx_pkg::seg_data_t row_data [total_rows][seg_count];
	lbus_rx_pkg::seg_mty_t row_mty [total_rows][seg_count];
	logic [seg_count-1:0] row_ena [total_rows];
	logic [seg_count-1:0] row_eop [total_rows];
	logic [seg_count-1:0] row_err [total_rows];
	lbus_rx_pkg::beat_data_t exp_data [total_rows];
	lbus_rx_pkg::beat_keep_t exp_keep [total_rows];
	// tvalid, tlast, tuser
	logic [2:0] exp_flags [total_rows];

	logic [127:0] vec_mem [vec_rows*words_per_row];
	integer seed;
	int error_count;
	int check_count;
	logic pkt_err_model;

	initial rx_clk = 1'b0;
	always #(clk_period/2) rx_clk = ~rx_clk;

	lbus_rx_top #(
		.rx_input_reg(rx_input_reg),
		.big_endian(big_endian)
	) i_dut (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.rx_lbus_data(rx_lbus_data),
		.rx_lbus_ena(rx_lbus_ena),
		.rx_lbus_eop(rx_lbus_eop),
		.rx_lbus_mty(rx_lbus_mty),
		.rx_lbus_err(rx_lbus_err),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tkeep(m_axis_tkeep),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tuser(m_axis_tuser)
	);

	task automatic check_value(input string name, input logic [511:0] expected,
		input logic [511:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic load_vectors();
		int base;
		logic [15:0] ctrl;
		$readmemh("test/lbus_rx_vectors.txt", vec_mem);
		for (int r = 0; r < vec_rows; r++) begin
			base = r * words_per_row;
			for (int k = 0; k < seg_count; k++) begin
				ctrl = vec_mem[base+4][(seg_count-1-k)*16 +: 16];
				row_data[r][k] = vec_mem[base+k];
				row_ena[r][k] = ctrl[12];
				row_eop[r][k] = ctrl[8];
				row_mty[r][k] = ctrl[7:4];
				row_err[r][k] = ctrl[0];
				exp_data[r][(seg_count-1-k)*seg_bits +: seg_bits] = vec_mem[base+7+k];
			end
			exp_keep[r] = vec_mem[base+5][63:0];
			exp_flags[r] = {vec_mem[base+6][8], vec_mem[base+6][4], vec_mem[base+6][0]};
		end
	endtask

	// expected beat byte by byte with segment 0 in the top bytes
	task automatic predict_row(input int r);
		logic kept;
		logic any_valid;
		logic any_last;
		logic any_err;
		int j;
		exp_data[r] = '0;
		exp_keep[r] = '0;
		any_valid = 1'b0;
		any_last = 1'b0;
		any_err = 1'b0;
		for (int k = 0; k < seg_count; k++) begin
			for (int b = 0; b < seg_bytes; b++) begin
				kept = row_ena[r][k] &&
					(!row_eop[r][k] || b < seg_bytes - int'(row_mty[r][k]));
				j = k * seg_bytes + b;
				if (kept) begin
					exp_data[r][(beat_bytes-1-j)*8 +: 8] =
						row_data[r][k][(seg_bytes-1-b)*8 +: 8];
					exp_keep[r][beat_bytes-1-j] = 1'b1;
				end
			end
			if (row_ena[r][k]) begin
				any_valid = 1'b1;
				any_last |= row_eop[r][k];
				any_err |= row_err[r][k];
			end
		end
		pkt_err_model = pkt_err_model | any_err;
		exp_flags[r] = {any_valid, any_last, any_last & pkt_err_model};
		if (any_last) begin
			pkt_err_model = 1'b0;
		end
	endtask

	task automatic make_random_rows();
		logic [31:0] rnd;
		int top;
		for (int r = vec_rows; r < total_rows; r++) begin
			rnd = $random(seed);
			row_ena[r] = rnd[3:0];
			top = -1;
			for (int k = 0; k < seg_count; k++) begin
				rnd = $random(seed);
				row_data[r][k] = {$random(seed), $random(seed), $random(seed), $random(seed)};
				row_mty[r][k] = rnd[7:4];
				row_eop[r][k] = rnd[8];
				row_err[r][k] = (rnd[11:9] == 3'd0);
				if (row_ena[r][k]) begin
					top = k;
				end
			end
			// end of packet only in the last enabled segment
			for (int k = 0; k < seg_count; k++) begin
				if (row_ena[r][k] && k != top) begin
					row_eop[r][k] = 1'b0;
				end
			end
			predict_row(r);
		end
	endtask

	task automatic drive_row(input int r);
		for (int k = 0; k < seg_count; k++) begin
			rx_lbus_data[k] = row_data[r][k];
			rx_lbus_mty[k] = row_mty[r][k];
		end
		rx_lbus_ena = row_ena[r];
		rx_lbus_eop = row_eop[r];
		rx_lbus_err = row_err[r];
	endtask

	task automatic drive_idle();
		for (int k = 0; k < seg_count; k++) begin
			rx_lbus_data[k] = '0;
			rx_lbus_mty[k] = '0;
		end
		rx_lbus_ena = '0;
		rx_lbus_eop = '0;
		rx_lbus_err = '0;
	endtask

	task automatic check_row(input int r);
		string tag;
		if (r < vec_rows) begin
			tag = $sformatf("vector row %0d", r);
		end else begin
			tag = $sformatf("random row %0d", r - vec_rows);
		end
		check_value({tag, " tdata"}, exp_data[r], m_axis_tdata);
		check_value({tag, " tkeep"}, 512'(exp_keep[r]), 512'(m_axis_tkeep));
		check_value({tag, " tvalid"}, 512'(exp_flags[r][2]), 512'(m_axis_tvalid));
		check_value({tag, " tlast"}, 512'(exp_flags[r][1]), 512'(m_axis_tlast));
		check_value({tag, " tuser"}, 512'(exp_flags[r][0]), 512'(m_axis_tuser));
	endtask

	initial begin : stimulus
		seed = 78;
		error_count = 0;
		check_count = 0;
		pkt_err_model = 1'b0;
		rst_n = 1'b0;
		load_vectors();
		make_random_rows();
		drive_row(7);
		repeat (reset_cycles) @(posedge rx_clk);
		@(negedge rx_clk);
		rst_n = 1'b1;
		// the bad full packet of row 7 held during reset must not come out
		check_value("after reset tvalid", 512'(1'b0), 512'(m_axis_tvalid));
		check_value("after reset tlast", 512'(1'b0), 512'(m_axis_tlast));
		check_value("after reset tuser", 512'(1'b0), 512'(m_axis_tuser));
		// one row per cycle and its outputs latency cycles later
		for (int c = 0; c < total_rows + latency; c++) begin
			if (c >= latency) begin
				check_row(c - latency);
			end
			if (c < total_rows) begin
				drive_row(c);
			end else begin
				drive_idle();
			end
			@(negedge rx_clk);
		end
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		#((total_rows + 20) * clk_period);
		$display("timeout: the test did not end within %0d clock periods", total_rows + 20);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== rtl/lbus_rx_top.sv ====
`timescale 1ns/10ps

module lbus_rx_top #(
	parameter int rx_input_reg = 0,
	parameter int big_endian = 1
) (
	input logic rx_clk,
	input logic rst_n,
	// lbus receive side, one entry per segment
	input lbus_rx_pkg::seg_data_t rx_lbus_data [lbus_rx_pkg::seg_count],
	input logic [lbus_rx_pkg::seg_count-1:0] rx_lbus_ena,
	input logic [lbus_rx_pkg::seg_count-1:0] rx_lbus_eop,
	input lbus_rx_pkg::seg_mty_t rx_lbus_mty [lbus_rx_pkg::seg_count],
	input logic [lbus_rx_pkg::seg_count-1:0] rx_lbus_err,
	// axi4-stream master, no tready
	output lbus_rx_pkg::beat_data_t m_axis_tdata,
	output lbus_rx_pkg::beat_keep_t m_axis_tkeep,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	output logic m_axis_tuser
);

	lbus_rx_pkg::seg_data_t seg_data [lbus_rx_pkg::seg_count];
	lbus_rx_pkg::seg_keep_t seg_keep [lbus_rx_pkg::seg_count];
	logic [lbus_rx_pkg::seg_count-1:0] seg_valid;
	logic [lbus_rx_pkg::seg_count-1:0] seg_last;
	logic [lbus_rx_pkg::seg_count-1:0] seg_err;

	lbus_rx_pkg::beat_data_t beat_data;
	lbus_rx_pkg::beat_keep_t beat_keep;
	logic beat_valid;
	logic beat_last;
	logic beat_err;

	// decode, 0 or 1 cycle
	lbus_seg_decode #(
		.rx_input_reg(rx_input_reg)
	) i_decode (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.rx_lbus_data(rx_lbus_data),
		.rx_lbus_ena(rx_lbus_ena),
		.rx_lbus_eop(rx_lbus_eop),
		.rx_lbus_mty(rx_lbus_mty),
		.rx_lbus_err(rx_lbus_err),
		.seg_data(seg_data),
		.seg_keep(seg_keep),
		.seg_valid(seg_valid),
		.seg_last(seg_last),
		.seg_err(seg_err)
	);

	// beat packing, 1 cycle
	lbus_beat_assemble i_assemble (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.seg_data(seg_data),
		.seg_keep(seg_keep),
		.seg_valid(seg_valid),
		.seg_last(seg_last),
		.seg_err(seg_err),
		.beat_data(beat_data),
		.beat_keep(beat_keep),
		.beat_valid(beat_valid),
		.beat_last(beat_last),
		.beat_err(beat_err)
	);

	// output order and register, 1 cycle
	axis_byte_order #(
		.big_endian(big_endian)
	) i_order (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.beat_data(beat_data),
		.beat_keep(beat_keep),
		.beat_valid(beat_valid),
		.beat_last(beat_last),
		.beat_err(beat_err),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tkeep(m_axis_tkeep),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tuser(m_axis_tuser)
	);

endmodule

// ==== rtl/axis_byte_order.sv ====
`timescale 1ns/10ps

module axis_byte_order #(
	parameter int big_endian = 1
) (
	input logic rx_clk,
	input logic rst_n,
	input lbus_rx_pkg::beat_data_t beat_data,
	input lbus_rx_pkg::beat_keep_t beat_keep,
	input logic beat_valid,
	input logic beat_last,
	input logic beat_err,
	output lbus_rx_pkg::beat_data_t m_axis_tdata,
	output lbus_rx_pkg::beat_keep_t m_axis_tkeep,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	output logic m_axis_tuser
);

	lbus_rx_pkg::beat_data_t order_data;
	lbus_rx_pkg::beat_keep_t order_keep;

	if (big_endian != 0) begin : g_big
		assign order_data = beat_data;
		assign order_keep = beat_keep;
	end else begin : g_little
		// byte j of the lbus beat becomes byte 63-j
		for (genvar j = 0; j < lbus_rx_pkg::beat_bytes; j++) begin : g_byte
			assign order_data[8*j +: 8] =
				beat_data[8*(lbus_rx_pkg::beat_bytes-1-j) +: 8];
			assign order_keep[j] = beat_keep[lbus_rx_pkg::beat_bytes-1-j];
		end
	end

	always_ff @(posedge rx_clk) begin
		m_axis_tdata <= order_data;
		m_axis_tkeep <= order_keep;
	end

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast <= 1'b0;
			m_axis_tuser <= 1'b0;
		end else begin
			m_axis_tvalid <= beat_valid;
			m_axis_tlast <= beat_last;
			m_axis_tuser <= beat_err;
		end
	end

endmodule

// ==== rtl/lbus_beat_assemble.sv ====
`timescale 1ns/10ps

module lbus_beat_assemble (
	input logic rx_clk,
	input logic rst_n,
	input lbus_rx_pkg::seg_data_t seg_data [lbus_rx_pkg::seg_count],
	input lbus_rx_pkg::seg_keep_t seg_keep [lbus_rx_pkg::seg_count],
	input logic [lbus_rx_pkg::seg_count-1:0] seg_valid,
	input logic [lbus_rx_pkg::seg_count-1:0] seg_last,
	input logic [lbus_rx_pkg::seg_count-1:0] seg_err,
	output lbus_rx_pkg::beat_data_t beat_data,
	output lbus_rx_pkg::beat_keep_t beat_keep,
	output logic beat_valid,
	output logic beat_last,
	output logic beat_err
);

	localparam int seg_bits = lbus_rx_pkg::seg_bytes * 8;

	lbus_rx_pkg::beat_data_t pack_data;
	lbus_rx_pkg::beat_keep_t pack_keep;
	logic any_valid;
	logic any_last;
	logic any_err;

	// sticky error of the packet in progress
	logic pkt_err;

	// segment 0 goes to the top of the beat
	always_comb begin
		for (int k = 0; k < lbus_rx_pkg::seg_count; k++) begin
			pack_data[(lbus_rx_pkg::seg_count-1-k)*seg_bits +: seg_bits] = seg_data[k];
			pack_keep[(lbus_rx_pkg::seg_count-1-k)*lbus_rx_pkg::seg_bytes +:
				lbus_rx_pkg::seg_bytes] = seg_keep[k];
		end
	end

	assign any_valid = |seg_valid;
	assign any_last = |seg_last;
	assign any_err = |seg_err;

	always_ff @(posedge rx_clk) begin
		beat_data <= pack_data;
		beat_keep <= pack_keep;
	end

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_valid <= 1'b0;
			beat_last <= 1'b0;
			beat_err <= 1'b0;
			pkt_err <= 1'b0;
		end else begin
			beat_valid <= any_valid;
			beat_last <= any_last;
			beat_err <= any_last & (pkt_err | any_err);
			if (any_valid) begin
				// last beat hands the flag out and starts the next packet clean
				if (any_last) begin
					pkt_err <= 1'b0;
				end else begin
					pkt_err <= pkt_err | any_err;
				end
			end
		end
	end

endmodule

// ==== rtl/lbus_seg_decode.sv ====
`timescale 1ns/10ps

module lbus_seg_decode #(
	parameter int rx_input_reg = 0
) (
	input logic rx_clk,
	input logic rst_n,
	input lbus_rx_pkg::seg_data_t rx_lbus_data [lbus_rx_pkg::seg_count],
	input logic [lbus_rx_pkg::seg_count-1:0] rx_lbus_ena,
	input logic [lbus_rx_pkg::seg_count-1:0] rx_lbus_eop,
	input lbus_rx_pkg::seg_mty_t rx_lbus_mty [lbus_rx_pkg::seg_count],
	input logic [lbus_rx_pkg::seg_count-1:0] rx_lbus_err,
	output lbus_rx_pkg::seg_data_t seg_data [lbus_rx_pkg::seg_count],
	output lbus_rx_pkg::seg_keep_t seg_keep [lbus_rx_pkg::seg_count],
	output logic [lbus_rx_pkg::seg_count-1:0] seg_valid,
	output logic [lbus_rx_pkg::seg_count-1:0] seg_last,
	output logic [lbus_rx_pkg::seg_count-1:0] seg_err
);

	localparam lbus_rx_pkg::seg_keep_t full_keep = '1;

	// segment inputs after the optional register
	lbus_rx_pkg::seg_data_t data_q [lbus_rx_pkg::seg_count];
	lbus_rx_pkg::seg_mty_t mty_q [lbus_rx_pkg::seg_count];
	logic [lbus_rx_pkg::seg_count-1:0] ena_q;
	logic [lbus_rx_pkg::seg_count-1:0] eop_q;
	logic [lbus_rx_pkg::seg_count-1:0] err_q;

	// one keep bit covers one byte lane of the segment
	function automatic lbus_rx_pkg::seg_data_t keep_to_mask(
		input lbus_rx_pkg::seg_keep_t keep
	);
		lbus_rx_pkg::seg_data_t mask;
		for (int b = 0; b < lbus_rx_pkg::seg_bytes; b++) begin
			mask[8*b +: 8] = {8{keep[b]}};
		end
		return mask;
	endfunction

	if (rx_input_reg != 0) begin : g_in_reg
		always_ff @(posedge rx_clk or negedge rst_n) begin
			if (!rst_n) begin
				ena_q <= '0;
			end else begin
				ena_q <= rx_lbus_ena;
			end
		end

		// payload and qualifiers, only read under ena_q
		always_ff @(posedge rx_clk) begin
			data_q <= rx_lbus_data;
			mty_q <= rx_lbus_mty;
			eop_q <= rx_lbus_eop;
			err_q <= rx_lbus_err;
		end
	end else begin : g_in_wire
		assign data_q = rx_lbus_data;
		assign mty_q = rx_lbus_mty;
		assign ena_q = rx_lbus_ena;
		assign eop_q = rx_lbus_eop;
		assign err_q = rx_lbus_err;
	end

	assign seg_valid = ena_q;
	assign seg_last = ena_q & eop_q;
	assign seg_err = ena_q & err_q;

	for (genvar k = 0; k < lbus_rx_pkg::seg_count; k++) begin : g_seg
		// byte 0 sits in the top lane, so the empty bytes are the low lanes
		assign seg_keep[k] = !ena_q[k] ? '0 :
			(eop_q[k] ? full_keep << mty_q[k] : full_keep);

		assign seg_data[k] = data_q[k] & keep_to_mask(seg_keep[k]);
	end

endmodule

// ==== rtl/lbus_rx_pkg.sv ====
package lbus_rx_pkg;

	// bus geometry
	localparam int seg_count = 4;
	localparam int seg_bytes = 16;
	localparam int mty_width = 4;
	localparam int beat_bytes = seg_count * seg_bytes;

	// one lbus segment
	typedef logic [seg_bytes*8-1:0] seg_data_t;
	typedef logic [seg_bytes-1:0] seg_keep_t;
	typedef logic [mty_width-1:0] seg_mty_t;

	// one axi4-stream beat, byte 0 in the top bits
	typedef logic [beat_bytes*8-1:0] beat_data_t;
	typedef logic [beat_bytes-1:0] beat_keep_t;

endpackage
